// ==== include/chacha_config.svh ====
`ifndef CHACHA_CONFIG_SVH
`define CHACHA_CONFIG_SVH

`define CHACHA_ROUNDS     20
`define CHACHA_REQ_DEPTH  2
`define CHACHA_BLK_DEPTH  2  // Also the initial credit count

// "expand 32-byte k"
`define CHACHA_CONST0     32'h61707865
`define CHACHA_CONST1     32'h3320646e
`define CHACHA_CONST2     32'h79622d32
`define CHACHA_CONST3     32'h6b206574

`endif

// ==== source/chacha_pkg.sv ====
package chacha_pkg;

    typedef logic [31:0] word_t;

    // Word j sits at bits 32j+31 to 32j, same layout as block_t
    typedef word_t [15:0] chacha_state_t;

    // Byte i of each field at bits 8i+7 to 8i (RFC 7539 order)
    typedef struct packed {
        logic [255:0] key;
        logic [31:0]  counter;
        logic [95:0]  nonce;
    } chacha_req_t;

    typedef logic [511:0] block_t;

endpackage

// ==== source/quarter_round.sv ====
`timescale 1ns/1ps

module quarter_round (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] c,
    input  logic [31:0] d,
    output logic [31:0] a_out,
    output logic [31:0] b_out,
    output logic [31:0] c_out,
    output logic [31:0] d_out
);
    function automatic logic [31:0] rotl(input logic [31:0] x, input int n);
        return (x << n) | (x >> (32 - n));
    endfunction

    logic [31:0] a1, b1, c1, d1;

    always_comb begin
        a1 = a + b;
        d1 = rotl(d ^ a1, 16);
        c1 = c + d1;
        b1 = rotl(b ^ c1, 12);
        a_out = a1 + b1;
        d_out = rotl(d1 ^ a_out, 8);
        c_out = c1 + d_out;
        b_out = rotl(b1 ^ c_out, 7);
    end
endmodule

// ==== source/block_fifo.sv ====
`timescale 1ns/1ps

module block_fifo import chacha_pkg::*; #(
    parameter type payload_t = block_t,
    parameter int  DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full,
    output logic     credit_return
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    payload_t mem [DEPTH];
    logic [AW-1:0]   wr_ptr, rd_ptr;
    logic [CNTW-1:0] count;
    logic            wr_en, rd_en;

    assign empty = (count == '0);
    assign full  = (count == CNTW'(DEPTH));
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign dout  = mem[rd_ptr];
    assign credit_return = rd_en;  // One slot freed per pop

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en) count <= count + 1'b1;
            else if (rd_en && !wr_en) count <= count - 1'b1;
        end
    end
endmodule

// ==== source/chacha_core.sv ====
`timescale 1ns/1ps
`include "chacha_config.svh"

module chacha_core import chacha_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_empty,
    input  chacha_req_t req,
    output logic        req_pop,
    output logic        blk_push,
    output block_t      blk,
    input  logic        credit_return
);
    localparam int ROUNDS = `CHACHA_ROUNDS;
    localparam int RCW = $clog2(ROUNDS + 1);
    localparam int CW = $clog2(`CHACHA_BLK_DEPTH + 1);
    localparam logic [RCW-1:0] LAST_ROUND = RCW'(ROUNDS);
    localparam logic [CW-1:0] INIT_CREDITS = CW'(`CHACHA_BLK_DEPTH);

    chacha_state_t init_state;
    chacha_state_t init_copy;
    chacha_state_t work_state;
    chacha_state_t round_out;
    logic [RCW-1:0] round_cnt;
    logic [CW-1:0]  credits;
    logic           busy;
    logic           diag;  // 0 = column round
    word_t qa [4];
    word_t qb [4];
    word_t qc [4];
    word_t qd [4];

    // Constants, key, counter, nonce from word 0 upwards
    assign init_state = {req.nonce, req.counter, req.key,
                         `CHACHA_CONST3, `CHACHA_CONST2, `CHACHA_CONST1, `CHACHA_CONST0};

    assign diag     = round_cnt[0];
    assign req_pop  = !req_empty && !busy && (credits != '0);
    assign blk_push = busy && (round_cnt == LAST_ROUND);

    for (genvar i = 0; i < 4; i++) begin : g_qr
        quarter_round qr (
            .a     (work_state[i]),
            .b     (diag ? work_state[4 + (i + 1) % 4] : work_state[4 + i]),
            .c     (diag ? work_state[8 + (i + 2) % 4] : work_state[8 + i]),
            .d     (diag ? work_state[12 + (i + 3) % 4] : work_state[12 + i]),
            .a_out (qa[i]),
            .b_out (qb[i]),
            .c_out (qc[i]),
            .d_out (qd[i])
        );
    end

    // Write results back to the words they came from
    always_comb begin
        round_out = work_state;
        for (int i = 0; i < 4; i++) begin
            round_out[i] = qa[i];
            if (diag) begin
                round_out[4 + (i + 1) % 4]  = qb[i];
                round_out[8 + (i + 2) % 4]  = qc[i];
                round_out[12 + (i + 3) % 4] = qd[i];
            end else begin
                round_out[4 + i]  = qb[i];
                round_out[8 + i]  = qc[i];
                round_out[12 + i] = qd[i];
            end
        end
    end

    always_comb begin
        for (int j = 0; j < 16; j++) begin
            blk[32*j +: 32] = work_state[j] + init_copy[j];  // Final addition
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            round_cnt <= '0;
        end else if (req_pop) begin
            busy      <= 1'b1;
            round_cnt <= '0;
        end else if (blk_push) begin
            busy <= 1'b0;
        end else if (busy) begin
            round_cnt <= round_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            work_state <= init_state;
            init_copy  <= init_state;
        end else if (busy && !blk_push) begin
            work_state <= round_out;
        end
    end

    // One credit per block slot, spent on pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= INIT_CREDITS;
        end else if (req_pop && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!req_pop && credit_return) begin
            credits <= credits + 1'b1;
        end
    end
endmodule

// ==== source/word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer import chacha_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   blk_empty,
    input  block_t blk,
    output logic   blk_pop,
    output logic   ks_valid,
    output word_t  ks_word,
    input  logic   ks_ready
);
    chacha_state_t held;
    logic [3:0]    word_idx;
    logic          last_xfer;

    assign last_xfer = ks_valid && ks_ready && (word_idx == 4'd15);
    // Refill when idle or as the last word leaves
    assign blk_pop = !blk_empty && (!ks_valid || last_xfer);
    assign ks_word = held[word_idx];

    always_ff @(posedge clk) begin
        if (blk_pop) held <= blk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ks_valid <= 1'b0;
            word_idx <= '0;
        end else if (blk_pop) begin
            ks_valid <= 1'b1;
            word_idx <= '0;
        end else if (last_xfer) begin
            ks_valid <= 1'b0;
        end else if (ks_valid && ks_ready) begin
            word_idx <= word_idx + 1'b1;
        end
    end
endmodule

// ==== source/chacha_top.sv ====
`timescale 1ns/1ps
`include "chacha_config.svh"

module chacha_top import chacha_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  chacha_req_t req,
    output logic        ks_valid,
    output word_t       ks_word,
    input  logic        ks_ready
);
    chacha_req_t req_head;
    logic        req_empty, req_full, req_pop;
    block_t      blk_in, blk_head;
    logic        blk_push, blk_pop, blk_empty, credit_return;

    assign req_ready = !req_full;

    block_fifo #(.payload_t(chacha_req_t), .DEPTH(`CHACHA_REQ_DEPTH)) req_fifo (
        .clk, .rst_n,
        .push (req_valid), .din (req),
        .pop (req_pop), .dout (req_head),
        .empty (req_empty), .full (req_full),
        .credit_return ()
    );

    chacha_core core (
        .clk, .rst_n,
        .req_empty, .req (req_head), .req_pop,
        .blk_push, .blk (blk_in), .credit_return
    );

    // Never full on push, credits reserve the slot
    block_fifo #(.payload_t(block_t), .DEPTH(`CHACHA_BLK_DEPTH)) blk_fifo (
        .clk, .rst_n,
        .push (blk_push), .din (blk_in),
        .pop (blk_pop), .dout (blk_head),
        .empty (blk_empty), .full (),
        .credit_return
    );

    word_serializer serializer (
        .clk, .rst_n,
        .blk_empty, .blk (blk_head), .blk_pop,
        .ks_valid, .ks_word, .ks_ready
    );
endmodule

// ==== sim/chacha_sva.sv ====
`timescale 1ns/1ps
`include "chacha_config.svh"

module chacha_sva import chacha_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  req_pop,
    input logic  blk_push,
    input logic  credit_return,
    input logic  ks_valid,
    input logic  ks_ready,
    input word_t ks_word
);
    localparam int LATENCY = `CHACHA_ROUNDS + 1;
    localparam int DEPTH = `CHACHA_BLK_DEPTH;

    int credits;  // Tracks pops against returns on the core's credit link

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= DEPTH;
        end else begin
            credits <= credits - (req_pop ? 1 : 0) + (credit_return ? 1 : 0);
        end
    end

    // The block being pushed still holds its credit
    push_reserved: assert property (@(posedge clk) disable iff (!rst_n)
        blk_push |-> (credits < DEPTH))
        else $error("block pushed without a reserved credit");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (credits >= 0) && (credits <= DEPTH))
        else $error("credit count out of range: %0d", credits);

    word_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ks_valid && !ks_ready) |=> (ks_valid && $stable(ks_word)))
        else $error("keystream word changed while stalled");

    push_latency: assert property (@(posedge clk) disable iff (!rst_n)
        blk_push == $past(req_pop, LATENCY))
        else $error("push not exactly %0d cycles after pop", LATENCY);
endmodule

// ==== sim/chacha_checker.sv ====
`timescale 1ns/1ps

module chacha_checker import chacha_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_ready,
    input  chacha_req_t req,
    input  logic        ks_valid,
    input  logic        ks_ready,
    input  word_t       ks_word,
    input  chacha_req_t known_req,
    input  block_t      known_blk,
    output int          mismatch_count,
    output int          protocol_count,
    output int          blocks_done,
    output int          stall_cycles
);
    // Quarter round word groups, columns first, then diagonals
    localparam logic [3:0] QI [32] = '{
        4'd0, 4'd4, 4'd8,  4'd12,  4'd1, 4'd5, 4'd9,  4'd13,
        4'd2, 4'd6, 4'd10, 4'd14,  4'd3, 4'd7, 4'd11, 4'd15,
        4'd0, 4'd5, 4'd10, 4'd15,  4'd1, 4'd6, 4'd11, 4'd12,
        4'd2, 4'd7, 4'd8,  4'd13,  4'd3, 4'd4, 4'd9,  4'd14
    };

    chacha_req_t req_q [$];
    block_t      cur_blk;
    logic        cur_known;  // Request matches the published vector
    int          word_idx;

    function automatic block_t model_block(input chacha_req_t r);
        word_t  s [16];
        word_t  x [16];
        word_t  a, b, c, d;
        block_t out;
        s[0] = 32'h61707865;
        s[1] = 32'h3320646e;
        s[2] = 32'h79622d32;
        s[3] = 32'h6b206574;
        for (int j = 0; j < 8; j++) s[4 + j] = r.key[32*j +: 32];
        s[12] = r.counter;
        for (int j = 0; j < 3; j++) s[13 + j] = r.nonce[32*j +: 32];
        x = s;
        for (int i = 0; i < 10; i++) begin  // Double rounds
            for (int q = 0; q < 8; q++) begin
                a = x[QI[4*q]];
                b = x[QI[4*q + 1]];
                c = x[QI[4*q + 2]];
                d = x[QI[4*q + 3]];
                a = a + b;
                d = d ^ a;
                d = {d[15:0], d[31:16]};
                c = c + d;
                b = b ^ c;
                b = {b[19:0], b[31:20]};
                a = a + b;
                d = d ^ a;
                d = {d[23:0], d[31:24]};
                c = c + d;
                b = b ^ c;
                b = {b[24:0], b[31:25]};
                x[QI[4*q]] = a;
                x[QI[4*q + 1]] = b;
                x[QI[4*q + 2]] = c;
                x[QI[4*q + 3]] = d;
            end
        end
        for (int j = 0; j < 16; j++) out[32*j +: 32] = x[j] + s[j];
        return out;
    endfunction

    task automatic check_word();
        word_t want;
        if (word_idx == 0) begin
            if (req_q.size() == 0) begin
                $display("ERROR at %0t: keystream word %h came out with no pending request",
                         $time, ks_word);
                protocol_count++;
                return;
            end
            cur_known = (req_q[0] == known_req);
            cur_blk = model_block(req_q.pop_front());
        end
        want = cur_blk[32*word_idx +: 32];
        if (ks_word !== want) begin
            $display("MISMATCH at %0t: block %0d word %0d got %h expected %h",
                     $time, blocks_done, word_idx, ks_word, want);
            mismatch_count++;
        end
        if (cur_known && (ks_word !== known_blk[32*word_idx +: 32])) begin
            $display("MISMATCH at %0t: block %0d word %0d got %h published %h",
                     $time, blocks_done, word_idx, ks_word, known_blk[32*word_idx +: 32]);
            mismatch_count++;
        end
        if (word_idx == 15) begin
            word_idx = 0;
            blocks_done++;
        end else begin
            word_idx++;
        end
    endtask

    // Mid-cycle sampling, transfers complete on the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            mismatch_count = 0;
            protocol_count = 0;
            blocks_done = 0;
            stall_cycles = 0;
            word_idx = 0;
            cur_known = 1'b0;
            req_q.delete();
        end else begin
            if (req_valid && req_ready) req_q.push_back(req);
            if (req_valid && !req_ready) stall_cycles++;
            if (ks_valid && ks_ready) check_word();
        end
    end
endmodule

// ==== sim/chacha_tb.sv ====
`timescale 1ns/1ps

module chacha_tb import chacha_pkg::*; ();
    localparam int NUM_ROWS = 7;
    localparam int NUM_PASSES = 2;  // Free-running, then random back-pressure
    localparam int DRAIN_CYCLES = 64;  // Longer than one block through core and serializer
    localparam int WATCHDOG_CYCLES = 200 * NUM_ROWS * NUM_PASSES + 500;

    // RFC 7539 section 2.3.2
    localparam chacha_req_t RFC_REQ = {
        256'h1f1e1d1c1b1a1918_1716151413121110_0f0e0d0c0b0a0908_0706050403020100,
        32'h00000001,
        96'h00000000_4a000000_09000000
    };
    localparam word_t RFC_WORDS [16] = '{
        32'he4e7f110, 32'h15593bd1, 32'h1fdd0f50, 32'hc47120a3,
        32'hc7f4d1c7, 32'h0368c033, 32'h9aaa2204, 32'h4e6cd4c3,
        32'h466482d2, 32'h09aa9f07, 32'h05d7c214, 32'ha2028bd9,
        32'hd19c12b5, 32'hb94e16de, 32'he883d0cb, 32'h4e3c50a2
    };

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    chacha_req_t req;
    logic        ks_valid;
    word_t       ks_word;
    logic        ks_ready;

    chacha_req_t req_table [NUM_ROWS];
    block_t      rfc_blk;
    word_t       rng;
    logic        bp_mode;
    int          mismatch_count, protocol_count, blocks_done, stall_cycles;
    int          end_errors;
    int          stalls_before;

    chacha_top chacha_top_inst (
        .clk, .rst_n,
        .req_valid, .req_ready, .req,
        .ks_valid, .ks_word, .ks_ready
    );

    chacha_checker checker_inst (
        .clk, .rst_n,
        .req_valid, .req_ready, .req,
        .ks_valid, .ks_ready, .ks_word,
        .known_req (RFC_REQ), .known_blk (rfc_blk),
        .mismatch_count, .protocol_count, .blocks_done, .stall_cycles
    );

    bind chacha_top chacha_sva sva_inst (
        .clk (clk), .rst_n (rst_n),
        .req_pop (req_pop), .blk_push (blk_push), .credit_return (credit_return),
        .ks_valid (ks_valid), .ks_ready (ks_ready), .ks_word (ks_word)
    );

    function automatic word_t next_rand();
        word_t x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic build_table();
        chacha_req_t r;
        req_table[0] = RFC_REQ;
        for (int i = 1; i < NUM_ROWS; i++) begin
            for (int w = 0; w < 8; w++) r.key[32*w +: 32] = next_rand();
            r.counter = next_rand();
            for (int w = 0; w < 3; w++) r.nonce[32*w +: 32] = next_rand();
            req_table[i] = r;
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_request(input chacha_req_t r);
        req = r;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin : ready_drive
        word_t r;
        #1;
        r = bp_mode ? next_rand() : 32'd0;
        ks_ready = bp_mode ? (r[2:0] < 3'd3) : 1'b1;  // Ready 3 of 8 cycles
    end

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        ks_ready = 1'b0;
        bp_mode = 1'b0;
        rng = 32'd8;
        end_errors = 0;
        for (int j = 0; j < 16; j++) rfc_blk[32*j +: 32] = RFC_WORDS[j];
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int p = 0; p < NUM_PASSES; p++) begin
            bp_mode = (p == 1);
            stalls_before = stall_cycles;
            for (int r = 0; r < NUM_ROWS; r++) send_request(req_table[r]);
            req_valid = 1'b0;
            wait (blocks_done == (p + 1) * NUM_ROWS);
            @(posedge clk);
            #1;
            if (bp_mode && (stall_cycles == stalls_before)) begin
                $display("ERROR: req_ready never fell while the output was stalled");
                end_errors++;
            end
        end
        bp_mode = 1'b0;
        // Extra words in this window have no request behind them
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        if (ks_valid) begin
            $display("ERROR: keystream output still active after the last block");
            end_errors++;
        end

        $display("Errors: %0d mismatches, %0d protocol, %0d end of run (%0d blocks checked)",
                 mismatch_count, protocol_count, end_errors, blocks_done);
        if (mismatch_count + protocol_count + end_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: keystream output incomplete after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end
endmodule

// ==== project.f ====
+incdir+include
source/chacha_pkg.sv
source/quarter_round.sv
source/block_fifo.sv
source/chacha_core.sv
source/word_serializer.sv
source/chacha_top.sv
sim/chacha_sva.sv
sim/chacha_checker.sv
sim/chacha_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f project.f --top-module chacha_tb \
    --Mdir obj_dir -o chacha_sim || { echo "Build failed"; exit 1; }

./obj_dir/chacha_sim | tee /dev/stderr | grep -F "Test passed" > /dev/null \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
